/* include/clock_display_consts.svh */
`ifndef CLOCK_DISPLAY_CONSTS_SVH
`define CLOCK_DISPLAY_CONSTS_SVH

// rtc read addresses, one per time register
`define RTC_ADDR_YEAR   8'h8d
`define RTC_ADDR_MONTH  8'h89
`define RTC_ADDR_DAY    8'h87
`define RTC_ADDR_HOUR   8'h85
`define RTC_ADDR_MIN    8'h83
`define RTC_ADDR_SEC    8'h81

// lcd commands
`define LCD_CMD_LINE2   8'hc0
`define LCD_CMD_HOME    8'h80

`define ASCII_ZERO      8'h30
`define ASCII_SPACE     8'h20
`define ASCII_BANG      8'h21

// row and field geometry
`define DISPLAY_COLUMNS 14
`define LABEL_LETTERS   5
`define TIME_FIELDS     6

`endif

/* source/rtc_pkg.sv */
package rtc_pkg;

    // also the encoding of the field selector switches
    typedef enum logic [2:0] {
        field_year   = 3'd1,
        field_month  = 3'd2,
        field_day    = 3'd3,
        field_hour   = 3'd4,
        field_minute = 3'd5,
        field_second = 3'd6
    } time_field_e;

    // two packed bcd digits, tens in the high nibble
    typedef logic [7:0] bcd_t;

endpackage

/* source/lcd_pkg.sv */
package lcd_pkg;

    // value is the register-select level
    typedef enum logic {
        kind_command = 1'b0,
        kind_data    = 1'b1
    } lcd_kind_e;

    typedef logic [7:0] lcd_char_t;

    typedef enum logic [2:0] {
        wait_empty,
        read_field,
        write_time,
        change_line,
        write_label,
        return_home
    } display_state_e;

endpackage

/* source/peripheral_if.sv */
`timescale 1ns/1ps

// one rtc register read per transfer
interface rtc_read_if;
    logic                valid;
    rtc_pkg::time_field_e field;
    logic                ready;
    logic                done;
    rtc_pkg::bcd_t       bcd;

    modport requester (output valid, field, input ready, done, bcd);
    modport agent (input valid, field, output ready, done, bcd);
    // register bank snoops completed reads
    modport monitor (input field, done, bcd);
endinterface

// one lcd byte per transfer
interface lcd_write_if;
    logic                valid;
    lcd_pkg::lcd_kind_e  kind;
    lcd_pkg::lcd_char_t  data;
    logic                ready;
    logic                done;

    modport requester (output valid, kind, data, input ready, done);
    modport agent (input valid, kind, data, output ready, done);
endinterface

/* source/rtc_reader.sv */
`timescale 1ns/1ps
`include "clock_display_consts.svh"

module rtc_reader (
    input  logic          clk,
    input  logic          reset_p,
    rtc_read_if.agent     chan,
    output logic [7:0]    addr_rtc,
    output logic          valid_rtc,
    input  logic          busy_rtc,
    input  rtc_pkg::bcd_t receive_rtc
);

    logic       active;
    logic       busy_q;
    logic       accept;
    logic       busy_rise;
    logic       busy_fall;
    logic [7:0] field_addr;

    assign chan.ready = !active;
    assign accept     = chan.valid && !active;
    assign busy_rise  = active && busy_rtc && !busy_q;
    // only counts once the request has been taken down
    assign busy_fall  = active && !valid_rtc && !busy_rtc && busy_q;

    always_comb begin
        case (chan.field)
            rtc_pkg::field_year:   field_addr = `RTC_ADDR_YEAR;
            rtc_pkg::field_month:  field_addr = `RTC_ADDR_MONTH;
            rtc_pkg::field_day:    field_addr = `RTC_ADDR_DAY;
            rtc_pkg::field_hour:   field_addr = `RTC_ADDR_HOUR;
            rtc_pkg::field_minute: field_addr = `RTC_ADDR_MIN;
            default:               field_addr = `RTC_ADDR_SEC;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_p) begin
            active    <= 1'b0;
            busy_q    <= 1'b0;
            valid_rtc <= 1'b0;
            chan.done <= 1'b0;
        end else begin
            busy_q    <= busy_rtc;
            chan.done <= busy_fall;
            if (accept) begin
                active    <= 1'b1;
                valid_rtc <= 1'b1;
            end else if (chan.done) begin
                active <= 1'b0;
            end else if (busy_rise) begin
                valid_rtc <= 1'b0;
            end
        end
    end

    // address and read data
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_rtc <= field_addr;
        end
        if (busy_fall) begin
            chan.bcd <= receive_rtc;
        end
    end

    // the chip must be idle whenever a new read is launched
    assert property (@(posedge clk) disable iff (reset_p) $rose(valid_rtc) |-> !busy_rtc);

endmodule

/* source/lcd_writer.sv */
`timescale 1ns/1ps

module lcd_writer (
    input  logic               clk,
    input  logic               reset_p,
    lcd_write_if.agent         chan,
    output lcd_pkg::lcd_char_t data_clcd,
    output logic               rs_clcd,
    output logic               rw_clcd,
    output logic               valid_clcd,
    input  logic               busy_clcd
);

    logic active;
    logic busy_q;
    logic accept;
    logic busy_rise;
    logic busy_fall;

    // the display is write only and never read back
    assign rw_clcd    = 1'b0;
    assign chan.ready = !active;
    assign accept     = chan.valid && !active;
    assign busy_rise  = active && busy_clcd && !busy_q;
    assign busy_fall  = active && !valid_clcd && !busy_clcd && busy_q;

    always_ff @(posedge clk) begin
        if (reset_p) begin
            active     <= 1'b0;
            busy_q     <= 1'b0;
            valid_clcd <= 1'b0;
            data_clcd  <= '0;
            rs_clcd    <= 1'b0;
            chan.done  <= 1'b0;
        end else begin
            busy_q    <= busy_clcd;
            chan.done <= busy_fall;
            if (accept) begin
                active     <= 1'b1;
                valid_clcd <= 1'b1;
                data_clcd  <= chan.data;
                rs_clcd    <= chan.kind;
            end else if (chan.done) begin
                active <= 1'b0;
            end else if (busy_rise) begin
                valid_clcd <= 1'b0;
            end
        end
    end

    // byte must not move while it is requested or the display is busy
    assert property (@(posedge clk) disable iff (reset_p)
        (valid_clcd || busy_clcd) |=> $stable(data_clcd));

endmodule

/* source/time_register_bank.sv */
`timescale 1ns/1ps
`include "clock_display_consts.svh"

module time_register_bank (
    input  logic               clk,
    input  logic               reset_p,
    rtc_read_if.monitor        rd,
    input  logic [3:0]         column,
    output lcd_pkg::lcd_char_t digit_char
);

    rtc_pkg::bcd_t bank [`TIME_FIELDS];
    logic [2:0]    wr_idx;
    logic [3:0]    pair;
    logic [2:0]    rd_idx;
    rtc_pkg::bcd_t sel_byte;
    logic [3:0]    nibble;

    function automatic lcd_pkg::lcd_char_t to_ascii(input logic [3:0] nib);
        if (nib > 4'd9) begin
            return `ASCII_BANG;
        end
        return `ASCII_ZERO + {4'd0, nib};
    endfunction

    // field enum starts at 1
    assign wr_idx = 3'(rd.field) - 3'd1;

    always_ff @(posedge clk) begin
        if (reset_p) begin
            for (int i = 0; i < `TIME_FIELDS; i++) begin
                bank[i] <= '0;
            end
        end else if (rd.done && wr_idx < 3'(`TIME_FIELDS)) begin
            bank[wr_idx] <= rd.bcd;
        end
    end

    // columns 2k+2 and 2k+3 hold field k
    assign pair     = column - 4'd2;
    assign rd_idx   = pair[3:1];
    assign sel_byte = (rd_idx < 3'(`TIME_FIELDS)) ? bank[rd_idx] : '0;
    assign nibble   = column[0] ? sel_byte[3:0] : sel_byte[7:4];

    always_comb begin
        if (column == 4'd0) begin
            digit_char = `ASCII_ZERO + 8'd2;
        end else if (column == 4'd1) begin
            digit_char = `ASCII_ZERO;
        end else if (column < 4'(`DISPLAY_COLUMNS)) begin
            digit_char = to_ascii(nibble);
        end else begin
            digit_char = `ASCII_SPACE;
        end
    end

endmodule

/* source/label_text_rom.sv */
`timescale 1ns/1ps
`include "clock_display_consts.svh"

module label_text_rom (
    input  logic [2:0]         sw,
    input  logic [3:0]         column,
    output lcd_pkg::lcd_char_t label_char
);

    logic [`LABEL_LETTERS*8-1:0] letters;
    logic [3:0]                  pos;

    always_comb begin
        case (sw)
            rtc_pkg::field_year:   letters = "YEAR ";
            rtc_pkg::field_month:  letters = "MONTH";
            rtc_pkg::field_day:    letters = "DAY  ";
            rtc_pkg::field_hour:   letters = "HOUR ";
            rtc_pkg::field_minute: letters = "MIN  ";
            rtc_pkg::field_second: letters = "SEC  ";
            default:               letters = "AAAAA";
        endcase
    end

    // first letter sits in the top byte of the string
    assign pos = 4'(`LABEL_LETTERS - 1) - column;

    assign label_char = (column < 4'(`LABEL_LETTERS)) ? letters[pos*8 +: 8] : `ASCII_SPACE;

endmodule

/* source/display_sequencer.sv */
`timescale 1ns/1ps
`include "clock_display_consts.svh"

module display_sequencer (
    input  logic               clk,
    input  logic               reset_p,
    input  logic               empty_reg,
    rtc_read_if.requester      rtc,
    lcd_write_if.requester     lcd,
    output logic [3:0]         column,
    input  lcd_pkg::lcd_char_t digit_char,
    input  lcd_pkg::lcd_char_t label_char
);

    lcd_pkg::display_state_e state;
    rtc_pkg::time_field_e    field_cnt;
    logic                    issued;
    logic                    lcd_phase;
    logic                    last_column;
    logic                    done;

    assign lcd_phase   = (state != lcd_pkg::wait_empty) && (state != lcd_pkg::read_field);
    assign last_column = (column == 4'(`DISPLAY_COLUMNS - 1));
    assign done        = (state == lcd_pkg::read_field) ? rtc.done : (lcd_phase && lcd.done);

    // hold the request until the agent takes it
    assign rtc.valid = (state == lcd_pkg::read_field) && !issued;
    assign rtc.field = field_cnt;
    assign lcd.valid = lcd_phase && !issued;

    always_comb begin
        case (state)
            lcd_pkg::write_time: begin
                lcd.kind = lcd_pkg::kind_data;
                lcd.data = digit_char;
            end
            lcd_pkg::write_label: begin
                lcd.kind = lcd_pkg::kind_data;
                lcd.data = label_char;
            end
            lcd_pkg::change_line: begin
                lcd.kind = lcd_pkg::kind_command;
                lcd.data = `LCD_CMD_LINE2;
            end
            default: begin
                lcd.kind = lcd_pkg::kind_command;
                lcd.data = `LCD_CMD_HOME;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_p) begin
            state     <= lcd_pkg::wait_empty;
            field_cnt <= rtc_pkg::field_year;
            column    <= 4'd0;
            issued    <= 1'b0;
        end else begin
            if ((rtc.valid && rtc.ready) || (lcd.valid && lcd.ready)) begin
                issued <= 1'b1;
            end else if (done) begin
                issued <= 1'b0;
            end
            case (state)
                lcd_pkg::wait_empty: begin
                    if (empty_reg) begin
                        state     <= lcd_pkg::read_field;
                        field_cnt <= rtc_pkg::field_year;
                    end
                end
                lcd_pkg::read_field: begin
                    if (done && field_cnt == rtc_pkg::field_second) begin
                        state  <= lcd_pkg::write_time;
                        column <= 4'd0;
                    end else if (done) begin
                        field_cnt <= rtc_pkg::time_field_e'(field_cnt + 3'd1);
                    end
                end
                lcd_pkg::write_time, lcd_pkg::write_label: begin
                    if (done && last_column) begin
                        state  <= (state == lcd_pkg::write_time) ? lcd_pkg::change_line
                                                                 : lcd_pkg::return_home;
                        column <= 4'd0;
                    end else if (done) begin
                        column <= column + 4'd1;
                    end
                end
                lcd_pkg::change_line: begin
                    if (done) state <= lcd_pkg::write_label;
                end
                default: begin
                    if (done) begin
                        state     <= lcd_pkg::read_field;
                        field_cnt <= rtc_pkg::field_year;
                    end
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset_p)
        column <= 4'(`DISPLAY_COLUMNS - 1));

endmodule

/* source/clock_display_top.sv */
`timescale 1ns/1ps

module clock_display_top (
    input  logic               clk,
    input  logic               reset_p,
    input  logic [2:0]         sw,
    input  logic               empty_reg,
    input  logic               busy_rtc,
    input  rtc_pkg::bcd_t      receive_rtc,
    input  logic               busy_clcd,
    output logic [7:0]         addr_rtc,
    output logic               valid_rtc,
    output lcd_pkg::lcd_char_t data_clcd,
    output logic               rs_clcd,
    output logic               rw_clcd,
    output logic               valid_clcd
);

    logic [3:0]         column;
    lcd_pkg::lcd_char_t digit_char;
    lcd_pkg::lcd_char_t label_char;

    rtc_read_if  rtc_chan ();
    lcd_write_if lcd_chan ();

    display_sequencer display_sequencer_i (
        .clk(clk), .reset_p(reset_p), .empty_reg(empty_reg), .rtc(rtc_chan.requester),
        .lcd(lcd_chan.requester), .column(column), .digit_char(digit_char),
        .label_char(label_char));

    rtc_reader rtc_reader_i (
        .clk(clk), .reset_p(reset_p), .chan(rtc_chan.agent), .addr_rtc(addr_rtc),
        .valid_rtc(valid_rtc), .busy_rtc(busy_rtc), .receive_rtc(receive_rtc));

    lcd_writer lcd_writer_i (
        .clk(clk), .reset_p(reset_p), .chan(lcd_chan.agent), .data_clcd(data_clcd),
        .rs_clcd(rs_clcd), .rw_clcd(rw_clcd), .valid_clcd(valid_clcd), .busy_clcd(busy_clcd));

    time_register_bank time_register_bank_i (
        .clk(clk), .reset_p(reset_p), .rd(rtc_chan.monitor), .column(column),
        .digit_char(digit_char));

    label_text_rom label_text_rom_i (.sw(sw), .column(column), .label_char(label_char));

endmodule

/* verif/peripheral_models.sv */
`timescale 1ns/1ps
`include "clock_display_consts.svh"

// answers rtc reads from the current row, year in the top byte
module rtc_model #(parameter int seed_value = 32'hcdb802d4) (
    input  logic          clk,
    input  logic          reset_p,
    input  logic [7:0]    addr_rtc,
    input  logic          valid_rtc,
    input  logic [47:0]   time_bytes,
    output logic          busy_rtc,
    output rtc_pkg::bcd_t receive_rtc,
    output logic          read_seen,
    output logic [7:0]    read_addr
);

    integer     seed;
    integer     hold;
    logic [7:0] answer;

    initial begin
        seed        = seed_value;
        hold        = 0;
        busy_rtc    = 1'b0;
        receive_rtc = '0;
        read_seen   = 1'b0;
        read_addr   = '0;
    end

    always_comb begin
        case (addr_rtc)
            `RTC_ADDR_YEAR:  answer = time_bytes[47:40];
            `RTC_ADDR_MONTH: answer = time_bytes[39:32];
            `RTC_ADDR_DAY:   answer = time_bytes[31:24];
            `RTC_ADDR_HOUR:  answer = time_bytes[23:16];
            `RTC_ADDR_MIN:   answer = time_bytes[15:8];
            `RTC_ADDR_SEC:   answer = time_bytes[7:0];
            default:         answer = 8'hee;
        endcase
    end

    always @(posedge clk) begin
        read_seen <= 1'b0;
        if (reset_p) begin
            busy_rtc <= 1'b0;
            hold     <= 0;
        end else if (busy_rtc) begin
            if (hold <= 1) begin
                busy_rtc <= 1'b0;
            end else begin
                hold <= hold - 1;
            end
        end else if (valid_rtc) begin
            busy_rtc    <= 1'b1;
            hold        <= 1 + ($unsigned($random(seed)) % 6);
            receive_rtc <= answer;
            read_seen   <= 1'b1;
            read_addr   <= addr_rtc;
        end
    end

endmodule

// takes lcd bytes and logs each one with its register select
module lcd_model #(parameter int seed_value = 32'hcdb802d4) (
    input  logic               clk,
    input  logic               reset_p,
    input  lcd_pkg::lcd_char_t data_clcd,
    input  logic               rs_clcd,
    input  logic               valid_clcd,
    output logic               busy_clcd,
    output logic               byte_seen,
    output logic               byte_rs,
    output lcd_pkg::lcd_char_t byte_data
);

    integer seed;
    integer hold;

    initial begin
        seed      = seed_value;
        hold      = 0;
        busy_clcd = 1'b0;
        byte_seen = 1'b0;
        byte_rs   = 1'b0;
        byte_data = '0;
    end

    always @(posedge clk) begin
        byte_seen <= 1'b0;
        if (reset_p) begin
            busy_clcd <= 1'b0;
            hold      <= 0;
        end else if (busy_clcd) begin
            if (hold <= 1) begin
                busy_clcd <= 1'b0;
            end else begin
                hold <= hold - 1;
            end
        end else if (valid_clcd) begin
            busy_clcd <= 1'b1;
            hold      <= 1 + ($unsigned($random(seed)) % 6);
            byte_seen <= 1'b1;
            byte_rs   <= rs_clcd;
            byte_data <= data_clcd;
        end
    end

endmodule

/* verif/tb_clock_display.sv */
`timescale 1ns/1ps
`include "clock_display_consts.svh"

module tb_clock_display;

    localparam int row_count      = 8;
    localparam int idle_cycles    = 20;
    localparam int timeout_cycles = row_count * 36 * 20 + 16 + idle_cycles;

    logic               clk = 1'b0;
    logic               reset_p;
    logic [2:0]         sw;
    logic               empty_reg;
    logic               busy_rtc;
    rtc_pkg::bcd_t      receive_rtc;
    logic               busy_clcd;
    logic [7:0]         addr_rtc;
    logic               valid_rtc;
    lcd_pkg::lcd_char_t data_clcd;
    logic               rs_clcd;
    logic               rw_clcd;
    logic               valid_clcd;
    logic [47:0]        time_bytes;
    logic               read_seen;
    logic [7:0]         read_addr;
    logic               byte_seen;
    logic               byte_rs;
    lcd_pkg::lcd_char_t byte_data;

    // year, month, day, hour, minute, second, then the label selector
    logic [50:0] stim [row_count];
    // bit 9 marks an lcd byte and bit 8 holds its register select
    logic [9:0]  expected [36];
    int          errors = 0;

    always #4 clk = ~clk;

    clock_display_top clock_display_top_i (
        .clk(clk), .reset_p(reset_p), .sw(sw), .empty_reg(empty_reg), .busy_rtc(busy_rtc),
        .receive_rtc(receive_rtc), .busy_clcd(busy_clcd), .addr_rtc(addr_rtc),
        .valid_rtc(valid_rtc), .data_clcd(data_clcd), .rs_clcd(rs_clcd), .rw_clcd(rw_clcd),
        .valid_clcd(valid_clcd));

    rtc_model rtc_model_i (
        .clk(clk), .reset_p(reset_p), .addr_rtc(addr_rtc), .valid_rtc(valid_rtc),
        .time_bytes(time_bytes), .busy_rtc(busy_rtc), .receive_rtc(receive_rtc),
        .read_seen(read_seen), .read_addr(read_addr));

    lcd_model lcd_model_i (
        .clk(clk), .reset_p(reset_p), .data_clcd(data_clcd), .rs_clcd(rs_clcd),
        .valid_clcd(valid_clcd), .busy_clcd(busy_clcd), .byte_seen(byte_seen),
        .byte_rs(byte_rs), .byte_data(byte_data));

    task automatic stop_with_error(input string msg);
        errors++;
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic logic [7:0] digit_ascii(input logic [3:0] nib);
        return (nib > 4'd9) ? 8'h21 : 8'h30 + {4'h0, nib};
    endfunction

    function automatic logic [39:0] label_letters(input logic [2:0] sel);
        case (sel)
            3'd1:    return "YEAR ";
            3'd2:    return "MONTH";
            3'd3:    return "DAY  ";
            3'd4:    return "HOUR ";
            3'd5:    return "MIN  ";
            3'd6:    return "SEC  ";
            default: return "AAAAA";
        endcase
    endfunction

    // six reads, fourteen digits, line change, fourteen label chars, home
    task automatic build_expected(input logic [50:0] row);
        logic [47:0] t;
        logic [39:0] letters;
        t       = row[50:3];
        letters = label_letters(row[2:0]);
        expected[0] = {2'b00, `RTC_ADDR_YEAR};
        expected[1] = {2'b00, `RTC_ADDR_MONTH};
        expected[2] = {2'b00, `RTC_ADDR_DAY};
        expected[3] = {2'b00, `RTC_ADDR_HOUR};
        expected[4] = {2'b00, `RTC_ADDR_MIN};
        expected[5] = {2'b00, `RTC_ADDR_SEC};
        expected[6] = {2'b11, 8'h32};
        expected[7] = {2'b11, 8'h30};
        for (int k = 0; k < 6; k++) begin
            expected[8 + 2 * k] = {2'b11, digit_ascii(t[47 - 8 * k -: 4])};
            expected[9 + 2 * k] = {2'b11, digit_ascii(t[43 - 8 * k -: 4])};
        end
        expected[20] = {2'b10, `LCD_CMD_LINE2};
        for (int c = 0; c < 14; c++) begin
            expected[21 + c] = {2'b11, (c < 5) ? letters[39 - 8 * c -: 8] : 8'h20};
        end
        expected[35] = {2'b10, `LCD_CMD_HOME};
    endtask

    // next transfer taken by either peripheral
    task automatic wait_transfer(output logic [9:0] seen);
        @(negedge clk);
        while (!read_seen && !byte_seen) begin
            @(negedge clk);
        end
        assert (!(read_seen && byte_seen))
        else stop_with_error("RTC and LCD transfers were started in the same cycle");
        seen = read_seen ? {2'b00, read_addr} : {1'b1, byte_rs, byte_data};
    endtask

    always @(negedge clk) begin
        assert (rw_clcd === 1'b0)
        else stop_with_error("the LCD was switched to read mode");
    end

    initial begin
        logic [9:0] seen;
        reset_p    = 1'b1;
        empty_reg  = 1'b0;
        sw         = 3'd0;
        time_bytes = '0;
        stim[0] = {8'h24, 8'h06, 8'h15, 8'h13, 8'h45, 8'h59, 3'd1};
        stim[1] = {8'h99, 8'h12, 8'h31, 8'h23, 8'h59, 8'h00, 3'd2};
        stim[2] = {8'hab, 8'h01, 8'h01, 8'h00, 8'h00, 8'h07, 3'd0};
        stim[3] = {8'h07, 8'h9f, 8'h28, 8'hfa, 8'h30, 8'h41, 3'd3};
        stim[4] = {8'h50, 8'h11, 8'h05, 8'h08, 8'hc3, 8'h12, 3'd4};
        stim[5] = {8'h33, 8'h04, 8'h19, 8'h21, 8'h02, 8'hee, 3'd5};
        stim[6] = {8'h00, 8'h10, 8'h10, 8'h10, 8'h10, 8'h10, 3'd6};
        stim[7] = {8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h06, 3'd7};
        repeat (16) @(posedge clk);
        reset_p    <= 1'b0;
        sw         <= stim[0][2:0];
        time_bytes <= stim[0][50:3];
        // nothing may move until the register interface is empty
        repeat (idle_cycles) begin
            @(negedge clk);
            assert (!valid_rtc && !valid_clcd)
            else stop_with_error("a transfer started before empty_reg was high");
        end
        @(posedge clk);
        empty_reg <= 1'b1;
        for (int r = 0; r < row_count; r++) begin
            build_expected(stim[r]);
            for (int n = 0; n < 36; n++) begin
                wait_transfer(seen);
                assert (seen == expected[n])
                else stop_with_error($sformatf(
                    "MISMATCH at %0t: pass %0d transfer %0d got %h, expected %h",
                    $time, r, n, seen, expected[n]));
            end
            // next pass picks up the new row after the home command
            if (r + 1 < row_count) begin
                @(posedge clk);
                sw         <= stim[r + 1][2:0];
                time_bytes <= stim[r + 1][50:3];
            end
        end
        if (errors == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("SIMULATION FAILED");
            $fatal(1, "%0d checks failed", errors);
        end
    end

    initial begin
        #(timeout_cycles * 8);
        $display("TIMEOUT: refresh passes did not finish within %0d cycles", timeout_cycles);
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* Bender.yml */
package:
  name: clock_display

sources:
  - include_dirs:
      - include
    files:
      - source/rtc_pkg.sv
      - source/lcd_pkg.sv
      - source/peripheral_if.sv
      - source/rtc_reader.sv
      - source/lcd_writer.sv
      - source/time_register_bank.sv
      - source/label_text_rom.sv
      - source/display_sequencer.sv
      - source/clock_display_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/peripheral_models.sv
      - verif/tb_clock_display.sv

/* tb.f */
+incdir+include
source/rtc_pkg.sv
source/lcd_pkg.sv
source/peripheral_if.sv
source/rtc_reader.sv
source/lcd_writer.sv
source/time_register_bank.sv
source/label_text_rom.sv
source/display_sequencer.sv
source/clock_display_top.sv
verif/peripheral_models.sv
verif/tb_clock_display.sv
